// ==== include/flash_map.svh ====
// Flash address map
`ifndef FLASH_MAP_SVH
`define FLASH_MAP_SVH

// data window 0x000000 .. 0x07ffff
localparam logic [23:0] FLASH_WINDOW_BASE = 24'h000000;
localparam logic [23:0] FLASH_WINDOW_MASK = 24'hF80000;

// control register 0x080000 .. 0x080007
localparam logic [23:0] CTRL_REG_ADDR  = 24'h080000;
localparam logic [23:0] CTRL_ADDR_MASK = 24'hFFFFF8;

// control register bits
localparam int CTRL_WEN_BIT    = 0;	// program enable
localparam int CTRL_ERASE_BIT  = 1;	// erase trigger, reads as zero
localparam int CTRL_SECTOR_LSB = 8;	// sector field 15:8
localparam int CTRL_SECTOR_W   = 8;

`endif

// ==== hw/flash_pkg.sv ====
// Flash subsystem package
package flash_pkg;

	`include "flash_map.svh"

	// word index taken from the byte address
	localparam int WIDX_LSB = 2;
	localparam int WIDX_MSB = 17;

	// host access handed from the bus controller to the register block
	typedef struct packed {
		logic [23:0] address;
		logic [31:0] wdata;
		logic        write;	// 1 = write, 0 = read
		logic        is_ctrl;	// hit the control register range
	} bus_access_t;

	typedef enum logic [1:0] {
		OP_READ    = 2'd0,
		OP_PROGRAM = 2'd1,
		OP_ERASE   = 2'd2
	} flash_op_e;

	// command toward the flash array
	typedef struct packed {
		flash_op_e   op;
		logic [15:0] word_index;
		logic [7:0]  sector;	// erase only
		logic [31:0] data;	// program only
	} flash_cmd_t;

endpackage

// ==== hw/bus_cycle_ctrl.sv ====
// Host bus cycle controller
`timescale 1ns/100ps

module bus_cycle_ctrl (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   n_as,
	input  logic                   n_ds,
	input  logic                   r_w,
	input  logic [23:0]            addr,
	input  logic [31:0]            wdata,
	output logic [31:0]            rdata,
	output logic                   term,
	output logic                   acc_req,
	output flash_pkg::bus_access_t acc,
	input  logic                   acc_ack,
	input  logic [31:0]            acc_rdata
);
	import flash_pkg::*;

	typedef enum logic [1:0] {IDLE, REQ, TERM, RELEASE} state_e;

	state_e state;
	logic hit_data;
	logic hit_ctrl;
	logic start;

	assign hit_data = (addr & FLASH_WINDOW_MASK) == FLASH_WINDOW_BASE;
	assign hit_ctrl = (addr & CTRL_ADDR_MASK) == CTRL_REG_ADDR;
	assign start = !n_as && !n_ds && (hit_data || hit_ctrl);	// decoded strobe pair

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			acc_req <= 1'b0;
			term <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						acc_req <= 1'b1;
						state <= REQ;
					end
				end
				REQ: begin
					if (acc_ack) begin
						term <= 1'b1;
						state <= TERM;
					end
				end
				TERM: begin
					// hold term until the master ends the cycle
					if (n_as) begin
						term <= 1'b0;
						acc_req <= 1'b0;
						state <= RELEASE;
					end
				end
				RELEASE: begin
					if (!acc_ack)
						state <= IDLE;	// handshake back to idle
				end
				default: state <= IDLE;
			endcase
		end
	end

	// access payload, frozen for the whole handshake
	always_ff @(posedge CLK) begin
		if (state == IDLE && start) begin
			acc.address <= addr;
			acc.wdata <= wdata;
			acc.write <= !r_w;
			acc.is_ctrl <= hit_ctrl;
		end
	end

	always_ff @(posedge CLK) begin
		if (state == REQ && acc_ack && !acc.write)
			rdata <= acc_rdata;	// read data for the host
	end

	a_acc_stable: assert property (@(posedge CLK) disable iff (!nRST)
		acc_req && $past(acc_req) |-> $stable(acc))
		else $error("access changed during handshake");

	a_no_term_idle: assert property (@(posedge CLK) disable iff (!nRST)
		state == IDLE |-> !term)
		else $error("term high while idle");

endmodule

// ==== hw/registers_flash.sv ====
// Flash register block
`timescale 1ns/100ps

module registers_flash #(
	parameter int FLASH_WORDS  = 256,
	parameter int SECTOR_WORDS = 32
) (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   acc_req,
	input  flash_pkg::bus_access_t acc,
	output logic                   acc_ack,
	output logic [31:0]            acc_rdata,
	output logic                   cmd_req,
	output flash_pkg::flash_cmd_t  cmd,
	input  logic                   cmd_ack,
	input  logic [31:0]            cmd_rdata
);
	import flash_pkg::*;

	localparam int NUM_SECTORS = FLASH_WORDS / SECTOR_WORDS;

	typedef enum logic [1:0] {IDLE, CMD, DROP, DONE} state_e;

	state_e state;
	logic ctrl_wen;
	logic [CTRL_SECTOR_W-1:0] ctrl_sector;
	logic [31:0] ctrl_rd;
	logic [15:0] idx;
	logic idx_ok;
	logic [CTRL_SECTOR_W-1:0] wr_sector;
	logic erase_go;
	logic need_cmd;
	flash_op_e op_next;
	logic accept;

	assign idx = acc.address[WIDX_MSB:WIDX_LSB];
	assign idx_ok = {16'h0, idx} < 32'(FLASH_WORDS);
	assign wr_sector = acc.wdata[CTRL_SECTOR_LSB +: CTRL_SECTOR_W];
	// sectors past the end of the array are dropped here
	assign erase_go = acc.wdata[CTRL_ERASE_BIT]
		&& ({{(32 - CTRL_SECTOR_W){1'b0}}, wr_sector} < 32'(NUM_SECTORS));
	assign accept = (state == IDLE) && acc_req;

	always_comb begin
		ctrl_rd = '0;
		ctrl_rd[CTRL_WEN_BIT] = ctrl_wen;
		ctrl_rd[CTRL_SECTOR_LSB +: CTRL_SECTOR_W] = ctrl_sector;
	end

	// which accesses turn into a flash command
	always_comb begin
		need_cmd = 1'b0;
		op_next = OP_READ;
		if (acc.is_ctrl) begin
			need_cmd = acc.write && erase_go;
			op_next = OP_ERASE;
		end else if (idx_ok) begin
			if (!acc.write) begin
				need_cmd = 1'b1;
				op_next = OP_READ;
			end else if (ctrl_wen) begin
				need_cmd = 1'b1;
				op_next = OP_PROGRAM;
			end
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			acc_ack <= 1'b0;
			cmd_req <= 1'b0;
			ctrl_wen <= 1'b0;
			ctrl_sector <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (acc_req) begin
						if (acc.is_ctrl && acc.write) begin
							ctrl_wen <= acc.wdata[CTRL_WEN_BIT];
							ctrl_sector <= wr_sector;
						end
						if (need_cmd) begin
							cmd_req <= 1'b1;
							state <= CMD;
						end else begin
							acc_ack <= 1'b1;	// ctrl, protected or out of range
							state <= DONE;
						end
					end
				end
				CMD: begin
					if (cmd_ack) begin
						cmd_req <= 1'b0;
						state <= DROP;
					end
				end
				DROP: begin
					if (!cmd_ack) begin
						acc_ack <= 1'b1;
						state <= DONE;
					end
				end
				DONE: begin
					if (!acc_req) begin
						acc_ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			cmd.op <= op_next;
			cmd.word_index <= idx;
			cmd.sector <= wr_sector;
			cmd.data <= acc.wdata;
			acc_rdata <= acc.is_ctrl ? ctrl_rd : '1;	// ones unless the array answers
		end else if (state == CMD && cmd_ack && cmd.op == OP_READ) begin
			acc_rdata <= cmd_rdata;
		end
	end

	a_cmd_req_rise: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(cmd_req) |-> !cmd_ack)
		else $error("cmd_req raised with cmd_ack still high");

endmodule

// ==== hw/flash_array.sv ====
// Behavioral flash array
`timescale 1ns/100ps

module flash_array #(
	parameter int FLASH_WORDS  = 256,
	parameter int SECTOR_WORDS = 32,
	parameter int ERASE_CYCLES = 16
) (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  cmd_req,
	input  flash_pkg::flash_cmd_t cmd,
	output logic                  cmd_ack,
	output logic [31:0]           cmd_rdata
);
	import flash_pkg::*;

	localparam int AW = $clog2(FLASH_WORDS);
	localparam int NUM_SECTORS = FLASH_WORDS / SECTOR_WORDS;
	localparam logic [AW:0] FILL_LAST = (AW + 1)'(SECTOR_WORDS - 1);

	typedef enum logic [1:0] {IDLE, BUSY, ACK} state_e;

	state_e state;
	logic [31:0] mem [FLASH_WORDS];
	logic [AW-1:0] widx;
	logic [AW-1:0] sector_base;
	logic [15:0] busy_cnt;
	logic [AW-1:0] fill_addr;
	logic [AW:0] fill_left;

	assign widx = cmd.word_index[AW-1:0];
	assign sector_base = AW'(32'(cmd.sector) * 32'(SECTOR_WORDS));

	// erase is a busy wait of ERASE_CYCLES + sector%4, then one word per cycle
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			cmd_ack <= 1'b0;
			busy_cnt <= '0;
			fill_addr <= '0;
			fill_left <= '0;
			for (int i = 0; i < FLASH_WORDS; i++)
				mem[i] <= '1;	// erased state
		end else begin
			case (state)
				IDLE: begin
					if (cmd_req) begin
						case (cmd.op)
							OP_PROGRAM: begin
								mem[widx] <= mem[widx] & cmd.data;	// bits only clear
								cmd_ack <= 1'b1;
								state <= ACK;
							end
							OP_ERASE: begin
								busy_cnt <= 16'(ERASE_CYCLES) + 16'(cmd.sector[1:0]);
								fill_addr <= sector_base;
								fill_left <= FILL_LAST;
								state <= BUSY;
							end
							default: begin
								cmd_ack <= 1'b1;	// read data latched below
								state <= ACK;
							end
						endcase
					end
				end
				BUSY: begin
					if (busy_cnt != '0) begin
						busy_cnt <= busy_cnt - 1'b1;
					end else begin
						mem[fill_addr] <= '1;
						fill_addr <= fill_addr + 1'b1;
						fill_left <= fill_left - 1'b1;
						if (fill_left == '0) begin
							cmd_ack <= 1'b1;	// last word of the sector
							state <= ACK;
						end
					end
				end
				ACK: begin
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == IDLE && cmd_req && cmd.op == OP_READ)
			cmd_rdata <= mem[widx];
	end

	a_erase_in_range: assert property (@(posedge CLK) disable iff (!nRST)
		state == IDLE && cmd_req && cmd.op == OP_ERASE
		|-> 32'(cmd.sector) < 32'(NUM_SECTORS))
		else $error("erase of sector outside the array");

endmodule

// ==== hw/flash_subsys_top.sv ====
// Flash subsystem top level
`timescale 1ns/100ps

module flash_subsys_top #(
	parameter int FLASH_WORDS  = 256,
	parameter int SECTOR_WORDS = 32,
	parameter int ERASE_CYCLES = 16
) (
	input  logic        CLK,
	input  logic        nRST,
	input  logic        n_as,
	input  logic        n_ds,
	input  logic        r_w,
	input  logic [23:0] addr,
	input  logic [31:0] wdata,
	output logic [31:0] rdata,
	output logic        term
);
	import flash_pkg::*;

	logic        acc_req;
	bus_access_t acc;
	logic        acc_ack;
	logic [31:0] acc_rdata;
	logic        cmd_req;
	flash_cmd_t  cmd;
	logic        cmd_ack;
	logic [31:0] cmd_rdata;

	bus_cycle_ctrl i_bus_cycle_ctrl (
		.CLK       (CLK),
		.nRST      (nRST),
		.n_as      (n_as),
		.n_ds      (n_ds),
		.r_w       (r_w),
		.addr      (addr),
		.wdata     (wdata),
		.rdata     (rdata),
		.term      (term),
		.acc_req   (acc_req),
		.acc       (acc),
		.acc_ack   (acc_ack),
		.acc_rdata (acc_rdata)
	);

	registers_flash #(
		.FLASH_WORDS  (FLASH_WORDS),
		.SECTOR_WORDS (SECTOR_WORDS)
	) i_registers_flash (
		.CLK       (CLK),
		.nRST      (nRST),
		.acc_req   (acc_req),
		.acc       (acc),
		.acc_ack   (acc_ack),
		.acc_rdata (acc_rdata),
		.cmd_req   (cmd_req),
		.cmd       (cmd),
		.cmd_ack   (cmd_ack),
		.cmd_rdata (cmd_rdata)
	);

	flash_array #(
		.FLASH_WORDS  (FLASH_WORDS),
		.SECTOR_WORDS (SECTOR_WORDS),
		.ERASE_CYCLES (ERASE_CYCLES)
	) i_flash_array (
		.CLK       (CLK),
		.nRST      (nRST),
		.cmd_req   (cmd_req),
		.cmd       (cmd),
		.cmd_ack   (cmd_ack),
		.cmd_rdata (cmd_rdata)
	);

endmodule

// ==== tests/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock #(
	parameter real PERIOD       = 8.0,
	parameter int  RESET_CYCLES = 8
) (
	output logic CLK,
	output logic nRST
);
	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2.0) CLK = ~CLK;
	end

	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 nRST = 1'b1;	// clear of the edge
	end

endmodule

// ==== tests/flash_subsys_tb.sv ====
// Flash subsystem testbench
`timescale 1ns/100ps

module flash_subsys_tb;
	import flash_pkg::*;

	localparam int FLASH_WORDS  = 256;
	localparam int SECTOR_WORDS = 32;
	localparam int ERASE_CYCLES = 16;
	localparam int DS_DELAY     = 4;	// n_ds trails n_as by this many cycles
	// about 120 accesses plus 10 erases
	localparam int TIMEOUT_CYCLES = 120 * 45 + 10 * 60;

	logic CLK;
	logic nRST;
	logic n_as;
	logic n_ds;
	logic r_w;
	logic [23:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic term;

	logic [31:0] ref_mem [FLASH_WORDS];
	integer seed;
	int cycles = 0;

	tb_clock #(.PERIOD(8.0), .RESET_CYCLES(8)) i_clock (.CLK(CLK), .nRST(nRST));

	flash_subsys_top #(
		.FLASH_WORDS  (FLASH_WORDS),
		.SECTOR_WORDS (SECTOR_WORDS),
		.ERASE_CYCLES (ERASE_CYCLES)
	) i_dut (
		.CLK   (CLK),
		.nRST  (nRST),
		.n_as  (n_as),
		.n_ds  (n_ds),
		.r_w   (r_w),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.term  (term)
	);

	a_term_after_as: assert property (@(posedge CLK) disable iff (!nRST)
		$fell(term) |-> $past(n_as))
		else begin
			$display("tests failed");
			$fatal(1, "term dropped while n_as was still low");
		end

	a_term_after_ds: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(term) |-> $past(!n_ds))
		else begin
			$display("tests failed");
			$fatal(1, "term raised before n_ds went low");
		end

	always @(posedge CLK) begin
		cycles++;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("tests failed");
			$fatal(1, "timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		assert (got === exp) else begin
			$display("FAILED %s: expected %h, actual %h", name, exp, got);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [31:0] ctrl_word(input logic wen, input logic erase,
			input logic [7:0] sector);
		logic [31:0] w;
		w = '0;
		w[CTRL_WEN_BIT] = wen;
		w[CTRL_ERASE_BIT] = erase;
		w[CTRL_SECTOR_LSB +: 8] = sector;
		return w;
	endfunction

	function automatic logic [23:0] word_addr(input int idx);
		return 24'(idx * 4);
	endfunction

	task automatic bus_idle_cycle();
		n_as = 1'b1;
		n_ds = 1'b1;
		@(posedge CLK);
		#1;
	endtask

	task automatic wait_term();
		do begin
			@(posedge CLK);
			#1;
		end while (!term);
	endtask

	// address strobe first, data strobe some cycles later
	task automatic start_strobes();
		n_as = 1'b0;
		repeat (DS_DELAY) begin
			@(posedge CLK);
			#1;
		end
		n_ds = 1'b0;
	endtask

	// strobes stay low one cycle past term
	task automatic end_cycle();
		@(posedge CLK);
		#1;
		bus_idle_cycle();
	endtask

	task automatic bus_write(input logic [23:0] a, input logic [31:0] d);
		addr = a;
		wdata = d;
		r_w = 1'b0;
		start_strobes();
		wait_term();
		end_cycle();
	endtask

	task automatic bus_read(input logic [23:0] a, output logic [31:0] d);
		addr = a;
		r_w = 1'b1;
		start_strobes();
		wait_term();
		d = rdata;	// valid with term
		end_cycle();
	endtask

	task automatic read_check(input string name, input int idx);
		logic [31:0] exp;
		logic [31:0] got;
		if (idx < FLASH_WORDS)
			exp = ref_mem[idx];
		else
			exp = '1;
		bus_read(word_addr(idx), got);
		check_value(name, exp, got);
	endtask

	// write enable must be set
	task automatic program_word(input int idx, input logic [31:0] d);
		bus_write(word_addr(idx), d);
		ref_mem[idx] = ref_mem[idx] & d;	// bits only clear
	endtask

	task automatic erase_sector(input int s);
		bus_write(CTRL_REG_ADDR, ctrl_word(1'b1, 1'b1, 8'(s)));
		for (int i = 0; i < SECTOR_WORDS; i++)
			ref_mem[s * SECTOR_WORDS + i] = '1;
	endtask

	initial begin
		logic [31:0] got;
		int idx;
		n_as = 1'b1;
		n_ds = 1'b1;
		r_w = 1'b1;
		addr = '0;
		wdata = '0;
		seed = 32'h174b;
		for (int i = 0; i < FLASH_WORDS; i++)
			ref_mem[i] = '1;
		wait (nRST);
		@(posedge CLK);
		#1;

		// erased after reset
		check_value("reset_term", 32'd0, {31'd0, term});
		for (int i = 0; i < 8; i++)
			read_check("erased_read", (i * 37) % FLASH_WORDS);
		read_check("erased_read", FLASH_WORDS - 1);
		bus_read(CTRL_REG_ADDR, got);
		check_value("ctrl_reset", 32'd0, got);

		bus_write(word_addr(5), 32'h0);	// wen still clear
		read_check("write_protect", 5);

		bus_write(CTRL_REG_ADDR, ctrl_word(1'b1, 1'b0, 8'd0));
		for (int i = 0; i < 20; i++) begin
			idx = $unsigned($random(seed)) % FLASH_WORDS;
			program_word(idx, $random(seed));
			read_check("and_program", idx);
		end
		program_word(idx, $random(seed));
		read_check("and_reprogram", idx);

		for (int i = 0; i < 8; i++) begin
			program_word(2 * SECTOR_WORDS + i * 4, $random(seed));
			program_word(3 * SECTOR_WORDS + i, $random(seed));
		end
		erase_sector(2);
		for (int i = 0; i < SECTOR_WORDS; i++)
			read_check("erase_sector", 2 * SECTOR_WORDS + i);
		for (int i = 0; i < 8; i++)
			read_check("erase_neighbor", 3 * SECTOR_WORDS + i);
		bus_read(CTRL_REG_ADDR, got);
		check_value("ctrl_sector", ctrl_word(1'b1, 1'b0, 8'd2), got);
		program_word(7 * SECTOR_WORDS + 3, 32'h0);
		erase_sector(7);	// longest erase
		read_check("erase_last", 7 * SECTOR_WORDS + 3);
		read_check("erase_keep", 3 * SECTOR_WORDS);

		// probe outside both windows
		addr = 24'h100000;
		r_w = 1'b1;
		n_as = 1'b0;
		n_ds = 1'b0;
		repeat (40) begin
			@(posedge CLK);
			#1;
			check_value("outside_window", 32'd0, {31'd0, term});
		end
		bus_idle_cycle();

		program_word(0, 32'h0f0f0f0f);	// word 0 is where index 256 would alias
		read_check("out_of_range_read", FLASH_WORDS);
		bus_write(word_addr(FLASH_WORDS), 32'h0);
		read_check("out_of_range_alias", 0);
		read_check("out_of_range_alias", FLASH_WORDS - 1);
		bus_write(CTRL_REG_ADDR, ctrl_word(1'b1, 1'b1, 8'(FLASH_WORDS / SECTOR_WORDS)));
		read_check("erase_out_of_range", 0);

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== flash_subsys_top.f ====
+incdir+include
hw/flash_pkg.sv
hw/bus_cycle_ctrl.sv
hw/registers_flash.sv
hw/flash_array.sv
hw/flash_subsys_top.sv
tests/tb_clock.sv
tests/flash_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: flash_subsys

sources:
  - include_dirs:
      - include
    files:
      - hw/flash_pkg.sv
      - hw/bus_cycle_ctrl.sv
      - hw/registers_flash.sv
      - hw/flash_array.sv
      - hw/flash_subsys_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/flash_subsys_tb.sv
